/* design/branchPkg.sv */
package branchPkg;

    // Sequence number of an in-flight operation, wraps around
    // Age between two values follows the signed difference of the pair
    typedef logic [5:0] SqN;

    // Instruction address
    typedef logic [31:0] Pc;

    // Tag of the fetch bundle an operation came from
    typedef logic [2:0] FetchId;

    // Slot in the branch predictor tables
    typedef logic [3:0] BranchId;

    // Free running event counter
    typedef logic [31:0] PerfCount;

    // Execution ports that can resolve control flow in one cycle
    localparam int DEFAULT_NUM_BRANCHES = 4;

    // Ports below this index are branch units with prediction data
    // The ports above it only raise flush requests
    localparam int DEFAULT_NUM_PRED_PORTS = 2;

endpackage

/* design/branchRedirect.sv */
`timescale 1ns/1ps

module branchRedirect #(
    parameter int numBranches  = branchPkg::DEFAULT_NUM_BRANCHES,
    parameter int numPredPorts = branchPkg::DEFAULT_NUM_PRED_PORTS
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // Resolved operations, one slice per execution port
    input  logic [numBranches-1:0]                opValid,
    input  branchPkg::SqN [numBranches-1:0]       opSqN,
    input  branchPkg::Pc [numBranches-1:0]        opPc,
    input  branchPkg::FetchId [numBranches-1:0]   opFetchId,
    input  branchPkg::BranchId [numBranches-1:0]  opBranchId,
    input  logic [numBranches-1:0]                opPredTaken,
    input  logic [numBranches-1:0]                opActualTaken,
    input  branchPkg::Pc [numBranches-1:0]        opPredTarget,
    input  branchPkg::Pc [numBranches-1:0]        opActualTarget,
    input  logic [numBranches-1:0]                opIndirect,
    input  logic [numBranches-1:0]                opFlushReq,

    input  branchPkg::SqN                         robCurSqN,
    input  branchPkg::SqN                         renameNextSqN,

    // Redirect toward fetch
    output logic                                  redirValid,
    output branchPkg::SqN                         redirSqN,
    output branchPkg::Pc                          redirDstPc,
    output branchPkg::FetchId                     redirFetchId,
    output branchPkg::BranchId                    redirBranchId,
    output logic                                  redirBranchTaken,
    output logic                                  redirPredicted,
    output logic                                  redirIndirect,

    output logic                                  flushActive,
    output branchPkg::PerfCount                   indirectCount
);

    import branchPkg::*;

    logic [numBranches-1:0]    candValid;
    SqN [numBranches-1:0]      candSqN;
    Pc [numBranches-1:0]       candDstPc;
    FetchId [numBranches-1:0]  candFetchId;
    BranchId [numBranches-1:0] candBranchId;
    logic [numBranches-1:0]    candBranchTaken;
    logic [numBranches-1:0]    candPredicted;
    logic [numBranches-1:0]    candIndirect;
    SqN                        flushSqN;

    for (genvar k = 0; k < numBranches; k++) begin : genResolver
        // Low ports are branch units, the rest raise flushes
        branchResolver #(
            .isPredPort (k < numPredPorts)
        ) branchResolver_inst (
            .clk             (clk),
            .rst             (rst),
            .opValid         (opValid[k]),
            .opSqN           (opSqN[k]),
            .opPc            (opPc[k]),
            .opFetchId       (opFetchId[k]),
            .opBranchId      (opBranchId[k]),
            .opPredTaken     (opPredTaken[k]),
            .opActualTaken   (opActualTaken[k]),
            .opPredTarget    (opPredTarget[k]),
            .opActualTarget  (opActualTarget[k]),
            .opIndirect      (opIndirect[k]),
            .opFlushReq      (opFlushReq[k]),
            .candValid       (candValid[k]),
            .candSqN         (candSqN[k]),
            .candDstPc       (candDstPc[k]),
            .candFetchId     (candFetchId[k]),
            .candBranchId    (candBranchId[k]),
            .candBranchTaken (candBranchTaken[k]),
            .candPredicted   (candPredicted[k]),
            .candIndirect    (candIndirect[k])
        );
    end

    branchSelector #(
        .numBranches  (numBranches),
        .numPredPorts (numPredPorts)
    ) branchSelector_inst (
        .clk              (clk),
        .rst              (rst),
        .candValid        (candValid),
        .candSqN          (candSqN),
        .candDstPc        (candDstPc),
        .candFetchId      (candFetchId),
        .candBranchId     (candBranchId),
        .candBranchTaken  (candBranchTaken),
        .candPredicted    (candPredicted),
        .candIndirect     (candIndirect),
        .flushActive      (flushActive),
        .flushSqN         (flushSqN),
        .redirValid       (redirValid),
        .redirSqN         (redirSqN),
        .redirDstPc       (redirDstPc),
        .redirFetchId     (redirFetchId),
        .redirBranchId    (redirBranchId),
        .redirBranchTaken (redirBranchTaken),
        .redirPredicted   (redirPredicted),
        .redirIndirect    (redirIndirect),
        .indirectCount    (indirectCount)
    );

    // Flush window follows the registered redirect
    flushTracker flushTracker_inst (
        .clk           (clk),
        .rst           (rst),
        .redirValid    (redirValid),
        .redirSqN      (redirSqN),
        .robCurSqN     (robCurSqN),
        .renameNextSqN (renameNextSqN),
        .flushActive   (flushActive),
        .flushSqN      (flushSqN)
    );

endmodule

/* design/branchResolver.sv */
`timescale 1ns/1ps

module branchResolver #(
    parameter bit isPredPort = 1'b1
) (
    input  logic              clk,
    input  logic              rst,

    // Operation leaving the execution port
    input  logic              opValid,
    input  branchPkg::SqN     opSqN,
    input  branchPkg::Pc      opPc,
    input  branchPkg::FetchId opFetchId,
    input  branchPkg::BranchId opBranchId,
    input  logic              opPredTaken,
    input  logic              opActualTaken,
    input  branchPkg::Pc      opPredTarget,
    input  branchPkg::Pc      opActualTarget,
    input  logic              opIndirect,
    input  logic              opFlushReq,

    // Registered redirect candidate
    output logic              candValid,
    output branchPkg::SqN     candSqN,
    output branchPkg::Pc      candDstPc,
    output branchPkg::FetchId candFetchId,
    output branchPkg::BranchId candBranchId,
    output logic              candBranchTaken,
    output logic              candPredicted,
    output logic              candIndirect
);

    import branchPkg::*;

    logic needRedirect;
    logic dirMiss;
    logic tgtMiss;
    Pc    fallThrough;
    Pc    dstPc;

    assign dirMiss     = opPredTaken != opActualTaken;              // Direction disagrees
    assign tgtMiss     = opActualTaken && (opActualTarget != opPredTarget);
    assign fallThrough = opPc + Pc'(4);

    // Decide if fetch went the wrong way and where it has to restart
    always_comb begin
        if (isPredPort) begin
            needRedirect = opValid && (dirMiss || tgtMiss);
            dstPc        = opActualTaken ? opActualTarget : fallThrough;
        end else begin
            // Flush ports restart at the address they were given
            needRedirect = opValid && opFlushReq;
            dstPc        = opActualTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            candValid <= 1'b0;
        end else begin
            candValid <= needRedirect;
        end
    end

    // Candidate payload, only meaningful while candValid is set
    always_ff @(posedge clk) begin
        candSqN     <= opSqN;
        candDstPc   <= dstPc;
        candFetchId <= opFetchId;
        if (isPredPort) begin
            candBranchId    <= opBranchId;
            candBranchTaken <= opActualTaken;
            candPredicted   <= 1'b1;              // Branch unit always has predictor state
            candIndirect    <= opIndirect;
        end else begin
            // No predictor entry behind a flush request
            candBranchId    <= '0;
            candBranchTaken <= 1'b0;
            candPredicted   <= 1'b0;
            candIndirect    <= 1'b0;
        end
    end

endmodule

/* design/branchSelector.sv */
`timescale 1ns/1ps

module branchSelector #(
    parameter int numBranches  = branchPkg::DEFAULT_NUM_BRANCHES,
    parameter int numPredPorts = branchPkg::DEFAULT_NUM_PRED_PORTS
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // One candidate per execution port
    input  logic [numBranches-1:0]                candValid,
    input  branchPkg::SqN [numBranches-1:0]       candSqN,
    input  branchPkg::Pc [numBranches-1:0]        candDstPc,
    input  branchPkg::FetchId [numBranches-1:0]   candFetchId,
    input  branchPkg::BranchId [numBranches-1:0]  candBranchId,
    input  logic [numBranches-1:0]                candBranchTaken,
    input  logic [numBranches-1:0]                candPredicted,
    input  logic [numBranches-1:0]                candIndirect,

    // Flush window from the tracker
    input  logic                                  flushActive,
    input  branchPkg::SqN                         flushSqN,

    // Redirect toward fetch
    output logic                                  redirValid,
    output branchPkg::SqN                         redirSqN,
    output branchPkg::Pc                          redirDstPc,
    output branchPkg::FetchId                     redirFetchId,
    output branchPkg::BranchId                    redirBranchId,
    output logic                                  redirBranchTaken,
    output logic                                  redirPredicted,
    output logic                                  redirIndirect,

    output branchPkg::PerfCount                   indirectCount
);

    import branchPkg::*;

    // True when a was issued before b, even across the wrap
    function automatic logic isOlder(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return diff[$bits(SqN)-1];
    endfunction

    logic    selValid;
    SqN      selSqN;
    Pc       selDstPc;
    FetchId  selFetchId;
    BranchId selBranchId;
    logic    selBranchTaken;
    logic    selPredicted;
    logic    selIndirect;

    // Keep the oldest candidate that passes the flush filter
    always_comb begin
        selValid       = 1'b0;
        selSqN         = '0;
        selDstPc       = '0;
        selFetchId     = '0;
        selBranchId    = '0;
        selBranchTaken = 1'b0;
        selPredicted   = 1'b0;
        selIndirect    = 1'b0;
        for (int i = 0; i < numBranches; i++) begin
            if (candValid[i] &&
                (!selValid || isOlder(candSqN[i], selSqN)) &&
                (!flushActive || isOlder(candSqN[i], flushSqN))) begin
                selValid   = 1'b1;
                selSqN     = candSqN[i];
                selDstPc   = candDstPc[i];
                selFetchId = candFetchId[i];
                if (i < numPredPorts) begin
                    selBranchId    = candBranchId[i];
                    selBranchTaken = candBranchTaken[i];
                    selPredicted   = candPredicted[i];
                    selIndirect    = candIndirect[i];
                end else begin
                    // A flush port may replace an earlier branch winner
                    selBranchId    = '0;
                    selBranchTaken = 1'b0;
                    selPredicted   = 1'b0;
                    selIndirect    = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            redirValid    <= 1'b0;
            indirectCount <= '0;
        end else begin
            redirValid <= selValid;                                   // One pulse per winner
            if (selValid && selIndirect) begin
                indirectCount <= indirectCount + PerfCount'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        redirSqN         <= selSqN;
        redirDstPc       <= selDstPc;
        redirFetchId     <= selFetchId;
        redirBranchId    <= selBranchId;
        redirBranchTaken <= selBranchTaken;
        redirPredicted   <= selPredicted;
        redirIndirect    <= selIndirect;
    end

endmodule

/* design/flushTracker.sv */
`timescale 1ns/1ps

module flushTracker (
    input  logic          clk,
    input  logic          rst,

    // Redirect leaving the selector
    input  logic          redirValid,
    input  branchPkg::SqN redirSqN,

    // Pipeline drain status
    input  branchPkg::SqN robCurSqN,
    input  branchPkg::SqN renameNextSqN,

    output logic          flushActive,
    output branchPkg::SqN flushSqN
);

    typedef enum logic {
        Idle,
        Flushing
    } flushState_t;

    flushState_t state;
    flushState_t nextState;
    logic        drained;

    // ROB head caught up with rename, nothing younger is left in flight
    assign drained = robCurSqN == renameNextSqN;

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (redirValid) nextState = Flushing;
            end
            Flushing: begin
                // A fresh redirect restarts the window
                if (!redirValid && drained) nextState = Idle;
            end
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= Idle;
            flushSqN <= '0;
        end else begin
            state <= nextState;
            if (redirValid) begin
                flushSqN <= redirSqN;             // Only older ops may redirect now
            end
        end
    end

    assign flushActive = state == Flushing;

endmodule

/* flist.f */
design/branchPkg.sv
design/branchResolver.sv
design/branchSelector.sv
design/flushTracker.sv
design/branchRedirect.sv
tests/branchRedirectTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module branchRedirectTb -f flist.f -o simv || exit 1

out=$(./obj_dir/simv 2>&1)
echo "$out"

echo "$out" | grep -qx "Everything OK" && echo "Simulation passed" || {
    echo "Simulation did not pass"
    exit 1
}

/* tests/branchRedirectTb.sv */
`timescale 1ns/1ps

module branchRedirectTb;

    import branchPkg::*;

    localparam int numBranches  = 4;
    localparam int numPredPorts = 2;
    localparam int redirTimeout = 10;    // Cycles to wait for a redirect pulse
    localparam int flushTimeout = 10;

    logic                      clk;
    logic                      rst;
    logic [numBranches-1:0]    opValid;
    SqN [numBranches-1:0]      opSqN;
    Pc [numBranches-1:0]       opPc;
    FetchId [numBranches-1:0]  opFetchId;
    BranchId [numBranches-1:0] opBranchId;
    logic [numBranches-1:0]    opPredTaken;
    logic [numBranches-1:0]    opActualTaken;
    Pc [numBranches-1:0]       opPredTarget;
    Pc [numBranches-1:0]       opActualTarget;
    logic [numBranches-1:0]    opIndirect;
    logic [numBranches-1:0]    opFlushReq;
    SqN                        robCurSqN;
    SqN                        renameNextSqN;
    logic                      redirValid;
    SqN                        redirSqN;
    Pc                         redirDstPc;
    FetchId                    redirFetchId;
    BranchId                   redirBranchId;
    logic                      redirBranchTaken;
    logic                      redirPredicted;
    logic                      redirIndirect;
    logic                      flushActive;
    PerfCount                  indirectCount;

    integer   seed;
    PerfCount expCount;                  // Indirect redirects selected so far

    branchRedirect #(
        .numBranches  (numBranches),
        .numPredPorts (numPredPorts)
    ) branchRedirect_inst (
        .clk (clk), .rst (rst),
        .opValid (opValid), .opSqN (opSqN), .opPc (opPc), .opFetchId (opFetchId),
        .opBranchId (opBranchId), .opPredTaken (opPredTaken), .opActualTaken (opActualTaken),
        .opPredTarget (opPredTarget), .opActualTarget (opActualTarget),
        .opIndirect (opIndirect), .opFlushReq (opFlushReq),
        .robCurSqN (robCurSqN), .renameNextSqN (renameNextSqN),
        .redirValid (redirValid), .redirSqN (redirSqN), .redirDstPc (redirDstPc),
        .redirFetchId (redirFetchId), .redirBranchId (redirBranchId),
        .redirBranchTaken (redirBranchTaken), .redirPredicted (redirPredicted),
        .redirIndirect (redirIndirect), .flushActive (flushActive),
        .indirectCount (indirectCount)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkSqN(input string testName, input string what, input SqN expected,
                            input SqN actual);
        if (actual !== expected)
            abortRun($sformatf("Error in %s: %s expected %0d, actual %0d",
                               testName, what, expected, actual));
    endtask

    task automatic checkPc(input string testName, input string what, input Pc expected,
                           input Pc actual);
        if (actual !== expected)
            abortRun($sformatf("Error in %s: %s expected 0x%08h, actual 0x%08h",
                               testName, what, expected, actual));
    endtask

    task automatic checkFetchId(input string testName, input string what,
                                input FetchId expected, input FetchId actual);
        if (actual !== expected)
            abortRun($sformatf("Error in %s: %s expected %0d, actual %0d",
                               testName, what, expected, actual));
    endtask

    task automatic checkBranchId(input string testName, input string what,
                                 input BranchId expected, input BranchId actual);
        if (actual !== expected)
            abortRun($sformatf("Error in %s: %s expected %0d, actual %0d",
                               testName, what, expected, actual));
    endtask

    task automatic checkCount(input string testName, input string what,
                              input PerfCount expected, input PerfCount actual);
        if (actual !== expected)
            abortRun($sformatf("Error in %s: %s expected %0d, actual %0d",
                               testName, what, expected, actual));
    endtask

    task automatic checkFlag(input string testName, input string what, input logic expected,
                             input logic actual);
        if (actual !== expected)
            abortRun($sformatf("Error in %s: %s expected %0b, actual %0b",
                               testName, what, expected, actual));
    endtask

    // Word aligned address
    function automatic Pc randomPc();
        Pc value;
        value = $random(seed);
        return value & 32'hffff_fffc;
    endfunction

    // Called right after a rising edge, the op is seen by the DUT on the next edge
    task automatic setBranchOp(input logic [1:0] port, input SqN sqN, input Pc pc,
                               input logic predTaken, input logic actualTaken,
                               input Pc predTarget, input Pc actualTarget, input logic indirect);
        opValid[port]        <= 1'b1;
        opSqN[port]          <= sqN;
        opPc[port]           <= pc;
        opFetchId[port]      <= sqN[2:0];
        opBranchId[port]     <= sqN[3:0];
        opPredTaken[port]    <= predTaken;
        opActualTaken[port]  <= actualTaken;
        opPredTarget[port]   <= predTarget;
        opActualTarget[port] <= actualTarget;
        opIndirect[port]     <= indirect;
        opFlushReq[port]     <= 1'b0;
    endtask

    // Branch fields carry junk here, a flush port has to drop them
    task automatic setFlushOp(input logic [1:0] port, input SqN sqN, input Pc target);
        opValid[port]        <= 1'b1;
        opSqN[port]          <= sqN;
        opPc[port]           <= randomPc();
        opFetchId[port]      <= sqN[2:0];
        opBranchId[port]     <= sqN[3:0];
        opActualTarget[port] <= target;
        opActualTaken[port]  <= 1'b1;
        opIndirect[port]     <= 1'b1;
        opFlushReq[port]     <= 1'b1;
    endtask

    // Drops the ops after one cycle, then samples redirValid at each falling edge
    task automatic watchRedirect(input int limit, output logic seen, output int cycles);
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(posedge clk);
            if (cycles == 0) begin
                opValid    <= '0;
                opFlushReq <= '0;
            end
            cycles++;
            @(negedge clk);
            seen = redirValid;
        end
    endtask

    task automatic expectRedirect(input string testName);
        logic seen;
        int   cycles;
        watchRedirect(redirTimeout, seen, cycles);
        if (!seen)
            abortRun($sformatf("Timeout in %s: no redirect arrived", testName));
        if (cycles != 2)
            abortRun($sformatf("Error in %s: latency expected 2, actual %0d", testName, cycles));
    endtask

    task automatic expectNoRedirect(input string testName, input int window);
        logic seen;
        int   cycles;
        watchRedirect(window, seen, cycles);
        if (seen)
            abortRun($sformatf("%s: a redirect with sequence number %0d was not expected",
                               testName, redirSqN));
    endtask

    task automatic waitFlush(input string testName, input logic level);
        int cycles;
        cycles = 0;
        while (flushActive !== level && cycles < flushTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (flushActive !== level)
            abortRun($sformatf("Timeout in %s: flushActive never went to %0b", testName, level));
    endtask

    // Flush level rises after each redirect and drops once the ROB is drained
    task automatic settleFlush(input string testName);
        waitFlush(testName, 1'b1);
        waitFlush(testName, 1'b0);
    endtask

    task automatic resetAndCorrectPrediction();
        Pc tgt;
        tgt = randomPc();
        @(negedge clk);
        checkFlag("resetAndCorrectPrediction", "redirValid", 1'b0, redirValid);
        checkFlag("resetAndCorrectPrediction", "flushActive", 1'b0, flushActive);
        checkCount("resetAndCorrectPrediction", "indirectCount", '0, indirectCount);
        @(posedge clk);
        setBranchOp(2'd0, 6'd4, randomPc(), 1'b1, 1'b1, tgt, tgt, 1'b0);
        expectNoRedirect("resetAndCorrectPrediction", 4);
    endtask

    task automatic dirMissNotTaken();
        Pc pc;
        pc = randomPc();
        @(posedge clk);
        setBranchOp(2'd1, 6'd5, pc, 1'b1, 1'b0, randomPc(), randomPc(), 1'b0);
        expectRedirect("dirMissNotTaken");
        checkSqN("dirMissNotTaken", "redirSqN", 6'd5, redirSqN);
        checkPc("dirMissNotTaken", "redirDstPc", pc + 32'd4, redirDstPc);  // Fall through
        checkFetchId("dirMissNotTaken", "redirFetchId", 3'd5, redirFetchId);
        checkBranchId("dirMissNotTaken", "redirBranchId", 4'd5, redirBranchId);
        checkFlag("dirMissNotTaken", "redirBranchTaken", 1'b0, redirBranchTaken);
        checkFlag("dirMissNotTaken", "redirPredicted", 1'b1, redirPredicted);
        @(negedge clk);
        checkFlag("dirMissNotTaken", "redirValid pulse end", 1'b0, redirValid);
        settleFlush("dirMissNotTaken");
    endtask

    task automatic oldestAcrossWrap();
        Pc t0;
        Pc t2;
        t0 = randomPc();
        t2 = randomPc();
        @(posedge clk);
        // 62 is the oldest of 62, 1, 63 and 3 once the wrap is taken into account
        setBranchOp(2'd0, 6'd62, randomPc(), 1'b0, 1'b1, randomPc(), t0, 1'b0);
        setBranchOp(2'd1, 6'd1, randomPc(), 1'b1, 1'b0, randomPc(), randomPc(), 1'b0);
        setFlushOp(2'd2, 6'd63, randomPc());
        setFlushOp(2'd3, 6'd3, randomPc());
        expectRedirect("oldestAcrossWrap");
        checkSqN("oldestAcrossWrap", "redirSqN", 6'd62, redirSqN);
        checkPc("oldestAcrossWrap", "redirDstPc", t0, redirDstPc);
        checkFetchId("oldestAcrossWrap", "redirFetchId", 3'd6, redirFetchId);
        checkBranchId("oldestAcrossWrap", "redirBranchId", 4'd14, redirBranchId);
        checkFlag("oldestAcrossWrap", "redirBranchTaken", 1'b1, redirBranchTaken);
        checkFlag("oldestAcrossWrap", "redirPredicted", 1'b1, redirPredicted);
        settleFlush("oldestAcrossWrap");
        @(posedge clk);
        // Flush request older than an indirect branch
        setBranchOp(2'd0, 6'd20, randomPc(), 1'b1, 1'b1, randomPc(), randomPc(), 1'b1);
        setFlushOp(2'd2, 6'd17, t2);
        expectRedirect("flushPortOldest");
        checkSqN("flushPortOldest", "redirSqN", 6'd17, redirSqN);
        checkPc("flushPortOldest", "redirDstPc", t2, redirDstPc);
        checkFetchId("flushPortOldest", "redirFetchId", 3'd1, redirFetchId);
        checkBranchId("flushPortOldest", "redirBranchId", 4'd0, redirBranchId);
        checkFlag("flushPortOldest", "redirBranchTaken", 1'b0, redirBranchTaken);
        checkFlag("flushPortOldest", "redirPredicted", 1'b0, redirPredicted);
        checkFlag("flushPortOldest", "redirIndirect", 1'b0, redirIndirect);
        checkCount("flushPortOldest", "indirectCount", expCount, indirectCount);
        settleFlush("flushPortOldest");
    endtask

    task automatic flushWindowFilter();
        @(posedge clk);
        robCurSqN     <= 6'd9;
        renameNextSqN <= 6'd14;           // ROB not drained yet
        setBranchOp(2'd0, 6'd10, randomPc(), 1'b0, 1'b1, randomPc(), randomPc(), 1'b0);
        expectRedirect("flushWindowFilter");
        checkSqN("flushWindowFilter", "redirSqN", 6'd10, redirSqN);
        waitFlush("flushWindowFilter", 1'b1);
        @(posedge clk);
        setBranchOp(2'd1, 6'd12, randomPc(), 1'b1, 1'b0, randomPc(), randomPc(), 1'b0);
        expectNoRedirect("flushWindowFilter", 4);
        checkFlag("flushWindowFilter", "flushActive", 1'b1, flushActive);
        @(posedge clk);
        setBranchOp(2'd0, 6'd8, randomPc(), 1'b1, 1'b0, randomPc(), randomPc(), 1'b0);
        expectRedirect("flushWindowFilter");
        checkSqN("flushWindowFilter", "redirSqN", 6'd8, redirSqN);
        @(posedge clk);
        robCurSqN <= 6'd14;
        waitFlush("flushWindowFilter", 1'b0);
    endtask

    task automatic indirectCounting();
        Pc predTgt;
        Pc realTgt;
        predTgt = randomPc();
        realTgt = predTgt + 32'd16;
        @(posedge clk);
        setBranchOp(2'd0, 6'd40, randomPc(), 1'b1, 1'b1, predTgt, realTgt, 1'b1);
        expectRedirect("indirectCounting");
        expCount = expCount + 32'd1;
        checkPc("indirectCounting", "redirDstPc", realTgt, redirDstPc);
        checkFlag("indirectCounting", "redirIndirect", 1'b1, redirIndirect);
        checkCount("indirectCounting", "indirectCount", expCount, indirectCount);
        settleFlush("indirectCounting");
        @(posedge clk);
        setBranchOp(2'd1, 6'd41, randomPc(), 1'b1, 1'b1, predTgt, realTgt, 1'b1);
        expectRedirect("indirectCounting");
        expCount = expCount + 32'd1;
        checkCount("indirectCounting", "indirectCount", expCount, indirectCount);
        settleFlush("indirectCounting");
        @(posedge clk);
        setBranchOp(2'd0, 6'd42, randomPc(), 1'b1, 1'b0, predTgt, realTgt, 1'b0);
        expectRedirect("indirectCounting");
        checkFlag("indirectCounting", "redirIndirect", 1'b0, redirIndirect);
        checkCount("indirectCounting", "indirectCount", expCount, indirectCount);
        settleFlush("indirectCounting");
    endtask

    initial begin
        seed           = 32'hd8f7;
        expCount       = '0;
        rst            <= 1'b1;
        opValid        <= '0;
        opSqN          <= '0;
        opPc           <= '0;
        opFetchId      <= '0;
        opBranchId     <= '0;
        opPredTaken    <= '0;
        opActualTaken  <= '0;
        opPredTarget   <= '0;
        opActualTarget <= '0;
        opIndirect     <= '0;
        opFlushReq     <= '0;
        robCurSqN      <= '0;
        renameNextSqN  <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        resetAndCorrectPrediction();
        dirMissNotTaken();
        oldestAcrossWrap();
        flushWindowFilter();
        indirectCounting();

        $display("Everything OK");
        $finish;
    end

endmodule
